// File: Makefile
VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= TB FAILED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(SIM_BIN) > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/alu.sv
`timescale 1ns/10ps
`include "ex_params.svh"

module alu
    import ex_pkg::*;
(
    input  alu_op_t aluop,
    input  word_t   reg1,
    input  word_t   reg2,
    output word_t   alu_result
);

    logic [$clog2(`DATA_WIDTH)-1:0] shamt;

    word_t logic_res;
    word_t shift_res;
    word_t addend;
    word_t sum_res;
    logic  is_sub;
    logic  lt_signed;
    logic  lt_unsigned;

    logic   mul_signed;
    dword_t mul_a;
    dword_t mul_b;
    dword_t product;

    assign shamt = reg2[$clog2(`DATA_WIDTH)-1:0];

    always_comb begin
        case (aluop)
            ALU_OR:  logic_res = reg1 | reg2;
            ALU_NOR: logic_res = ~(reg1 | reg2);
            ALU_AND: logic_res = reg1 & reg2;
            ALU_XOR: logic_res = reg1 ^ reg2;
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (aluop)
            ALU_SLL: shift_res = reg1 << shamt;
            ALU_SRL: shift_res = reg1 >> shamt;
            ALU_SRA: shift_res = word_t'($signed(reg1) >>> shamt);
            default: shift_res = '0;
        endcase
    end

    // subtract as add of the inverted operand plus one
    assign is_sub  = (aluop == ALU_SUB);
    assign addend  = is_sub ? ~reg2 : reg2;
    assign sum_res = reg1 + addend + word_t'(is_sub);

    assign lt_signed   = $signed(reg1) < $signed(reg2);
    assign lt_unsigned = reg1 < reg2;

    // sign or zero extend to full product width, low 64 bits are exact
    assign mul_signed = (aluop == ALU_MUL) || (aluop == ALU_MULH);
    assign mul_a = mul_signed ? {{`DATA_WIDTH{reg1[`DATA_WIDTH-1]}}, reg1}
                              : {{`DATA_WIDTH{1'b0}}, reg1};
    assign mul_b = mul_signed ? {{`DATA_WIDTH{reg2[`DATA_WIDTH-1]}}, reg2}
                              : {{`DATA_WIDTH{1'b0}}, reg2};
    assign product = mul_a * mul_b;

    always_comb begin
        case (aluop)
            ALU_OR, ALU_NOR, ALU_AND, ALU_XOR: begin
                alu_result = logic_res;
            end
            ALU_SLL, ALU_SRL, ALU_SRA: begin
                alu_result = shift_res;
            end
            ALU_ADD, ALU_SUB: begin
                alu_result = sum_res;
            end
            ALU_SLT:  alu_result = word_t'(lt_signed);
            ALU_SLTU: alu_result = word_t'(lt_unsigned);
            ALU_MUL:  alu_result = product[`DATA_WIDTH-1:0];
            ALU_MULH, ALU_MULHU: begin
                alu_result = product[2*`DATA_WIDTH-1:`DATA_WIDTH];
            end
            // memory ops and nop
            default:  alu_result = '0;
        endcase
    end

endmodule

// File: hdl/ex_params.svh
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// datapath widths
`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5
`define CSR_ADDR_WIDTH  14
`define EXC_CAUSE_WIDTH 7

// one strobe bit per byte of a data word
`define STRB_WIDTH      4

// link bit control register
`define CSR_LLBCTL      14'h0060

// address alignment fault
`define EXC_ALE         7'h09

`endif

// File: hdl/ex_pkg.sv
`include "ex_params.svh"

package ex_pkg;

    typedef logic [`DATA_WIDTH-1:0]      word_t;
    typedef logic [2*`DATA_WIDTH-1:0]    dword_t;
    typedef logic [`REG_ADDR_WIDTH-1:0]  reg_addr_t;
    typedef logic [`CSR_ADDR_WIDTH-1:0]  csr_addr_t;
    typedef logic [`EXC_CAUSE_WIDTH-1:0] exc_cause_t;
    typedef logic [`STRB_WIDTH-1:0]      wstrb_t;

    // immediate forms are folded into these by the decoder
    typedef enum logic [4:0] {
        ALU_NOP   = 5'd0,
        // logic
        ALU_OR    = 5'd1,
        ALU_NOR   = 5'd2,
        ALU_AND   = 5'd3,
        ALU_XOR   = 5'd4,
        // shift
        ALU_SLL   = 5'd5,
        ALU_SRL   = 5'd6,
        ALU_SRA   = 5'd7,
        // arithmetic
        ALU_ADD   = 5'd8,
        ALU_SUB   = 5'd9,
        ALU_SLT   = 5'd10,
        ALU_SLTU  = 5'd11,
        // multiply
        ALU_MUL   = 5'd12,
        ALU_MULH  = 5'd13,
        ALU_MULHU = 5'd14,
        // loads
        ALU_LDB   = 5'd15,
        ALU_LDBU  = 5'd16,
        ALU_LDH   = 5'd17,
        ALU_LDHU  = 5'd18,
        ALU_LDW   = 5'd19,
        ALU_LLW   = 5'd20,
        // stores
        ALU_STB   = 5'd21,
        ALU_STH   = 5'd22,
        ALU_STW   = 5'd23,
        ALU_SCW   = 5'd24
    } alu_op_t;

endpackage

// File: hdl/ex_stage.sv
`timescale 1ns/10ps
`include "ex_params.svh"

module ex_stage
    import ex_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       in_valid,
    input  alu_op_t    aluop,
    input  word_t      reg1,
    input  word_t      reg2,
    input  word_t      inst,
    input  logic       reg_write_en,
    input  reg_addr_t  reg_write_addr,

    input  logic       llbit,
    input  logic       mem_csr_write_en,
    input  csr_addr_t  mem_csr_write_addr,
    input  word_t      mem_csr_write_data,
    input  logic       wb_csr_write_en,
    input  csr_addr_t  wb_csr_write_addr,
    input  word_t      wb_csr_write_data,

    output logic       dc_valid,
    output logic       dc_op,
    output word_t      dc_addr,
    output wstrb_t     dc_wstrb,
    output word_t      dc_wdata,
    input  logic       dc_addr_ok,

    output logic       pause,

    output logic       out_valid,
    output logic       out_reg_write_en,
    output reg_addr_t  out_reg_write_addr,
    output word_t      out_reg_write_data,
    output word_t      out_mem_addr,
    output logic       out_exception,
    output exc_cause_t out_exc_cause,
    output logic       out_csr_write_en,
    output csr_addr_t  out_csr_addr,
    output word_t      out_csr_data,
    output logic       out_is_llw_scw
);

    word_t      alu_result;
    word_t      result;
    logic       llbit_now;
    logic       exception;
    exc_cause_t exc_cause;
    logic       csr_write_en;
    csr_addr_t  csr_addr;
    word_t      csr_data;
    logic       is_llw_scw;
    logic       load_en;

    alu i_alu (
        .aluop      (aluop),
        .reg1       (reg1),
        .reg2       (reg2),
        .alu_result (alu_result)
    );

    llbit_ctrl i_llbit_ctrl (
        .aluop              (aluop),
        .llbit              (llbit),
        .mem_csr_write_en   (mem_csr_write_en),
        .mem_csr_write_addr (mem_csr_write_addr),
        .mem_csr_write_data (mem_csr_write_data),
        .wb_csr_write_en    (wb_csr_write_en),
        .wb_csr_write_addr  (wb_csr_write_addr),
        .wb_csr_write_data  (wb_csr_write_data),
        .llbit_now          (llbit_now),
        .csr_write_en       (csr_write_en),
        .csr_addr           (csr_addr),
        .csr_data           (csr_data),
        .is_llw_scw         (is_llw_scw)
    );

    mem_access_unit i_mem_access_unit (
        .in_valid  (in_valid),
        .aluop     (aluop),
        .reg1      (reg1),
        .reg2      (reg2),
        .inst      (inst),
        .llbit_now (llbit_now),
        .mem_addr  (dc_addr),
        .dc_valid  (dc_valid),
        .dc_op     (dc_op),
        .dc_wstrb  (dc_wstrb),
        .dc_wdata  (dc_wdata),
        .exception (exception),
        .exc_cause (exc_cause)
    );

    // sc reports whether the link held, other memory ops leave zero from the alu
    always_comb begin
        if (aluop == ALU_SCW) begin
            result = {{(`DATA_WIDTH-1){1'b0}}, llbit_now};
        end else begin
            result = alu_result;
        end
    end

    assign pause   = dc_valid && !dc_addr_ok;
    assign load_en = in_valid && !pause;

    // control bits drop to a bubble whenever nothing is loaded
    always_ff @(posedge clk) begin
        if (reset || !load_en) begin
            out_valid        <= 1'b0;
            out_reg_write_en <= 1'b0;
            out_csr_write_en <= 1'b0;
            out_exception    <= 1'b0;
            out_is_llw_scw   <= 1'b0;
        end else begin
            out_valid        <= 1'b1;
            out_reg_write_en <= reg_write_en;
            out_csr_write_en <= csr_write_en;
            out_exception    <= exception;
            out_is_llw_scw   <= is_llw_scw;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            out_reg_write_addr <= reg_write_addr;
            out_reg_write_data <= result;
            out_mem_addr       <= dc_addr;
            out_exc_cause      <= exc_cause;
            out_csr_addr       <= csr_addr;
            out_csr_data       <= csr_data;
        end
    end

endmodule

// File: hdl/llbit_ctrl.sv
`timescale 1ns/10ps
`include "ex_params.svh"

module llbit_ctrl
    import ex_pkg::*;
(
    input  alu_op_t   aluop,
    input  logic      llbit,
    input  logic      mem_csr_write_en,
    input  csr_addr_t mem_csr_write_addr,
    input  word_t     mem_csr_write_data,
    input  logic      wb_csr_write_en,
    input  csr_addr_t wb_csr_write_addr,
    input  word_t     wb_csr_write_data,
    output logic      llbit_now,
    output logic      csr_write_en,
    output csr_addr_t csr_addr,
    output word_t     csr_data,
    output logic      is_llw_scw
);

    // younger stage wins, the status register copy is stale while a write is in flight
    always_comb begin
        if (mem_csr_write_en && (mem_csr_write_addr == `CSR_LLBCTL)) begin
            llbit_now = mem_csr_write_data[0];
        end else if (wb_csr_write_en && (wb_csr_write_addr == `CSR_LLBCTL)) begin
            llbit_now = wb_csr_write_data[0];
        end else begin
            llbit_now = llbit;
        end
    end

    always_comb begin
        csr_write_en = 1'b0;
        csr_addr     = '0;
        csr_data     = '0;
        is_llw_scw   = 1'b0;
        if (aluop == ALU_LLW) begin
            csr_write_en = 1'b1;
            csr_addr     = `CSR_LLBCTL;
            csr_data     = word_t'(1);
            is_llw_scw   = 1'b1;
        end else if ((aluop == ALU_SCW) && llbit_now) begin
            // successful sc consumes the link
            csr_write_en = 1'b1;
            csr_addr     = `CSR_LLBCTL;
            is_llw_scw   = 1'b1;
        end
    end

endmodule

// File: hdl/mem_access_unit.sv
`timescale 1ns/10ps
`include "ex_params.svh"

module mem_access_unit
    import ex_pkg::*;
(
    input  logic       in_valid,
    input  alu_op_t    aluop,
    input  word_t      reg1,
    input  word_t      reg2,
    input  word_t      inst,
    input  logic       llbit_now,
    output word_t      mem_addr,
    output logic       dc_valid,
    output logic       dc_op,
    output wstrb_t     dc_wstrb,
    output word_t      dc_wdata,
    output logic       exception,
    output exc_cause_t exc_cause
);

    word_t si12_ext;
    word_t si14_ext;
    logic  mem_req;

    assign si12_ext = {{(`DATA_WIDTH-12){inst[21]}}, inst[21:10]};
    // sc offset is in words
    assign si14_ext = {{(`DATA_WIDTH-16){inst[23]}}, inst[23:10], 2'b00};

    always_comb begin
        case (aluop)
            ALU_LDB, ALU_LDBU, ALU_LDH, ALU_LDHU, ALU_LDW, ALU_LLW: begin
                mem_addr = reg1 + reg2;
            end
            ALU_STB, ALU_STH, ALU_STW: begin
                mem_addr = reg1 + si12_ext;
            end
            ALU_SCW: mem_addr = reg1 + si14_ext;
            default: mem_addr = '0;
        endcase
    end

    always_comb begin
        mem_req  = 1'b0;
        dc_op    = 1'b0;
        dc_wstrb = '0;
        dc_wdata = '0;
        case (aluop)
            ALU_LDB, ALU_LDBU, ALU_LDH, ALU_LDHU, ALU_LDW, ALU_LLW: begin
                mem_req = 1'b1;
            end
            ALU_STB: begin
                mem_req  = 1'b1;
                dc_op    = 1'b1;
                dc_wdata = {`STRB_WIDTH{reg2[7:0]}};
                dc_wstrb = wstrb_t'(1) << mem_addr[1:0];
            end
            ALU_STH: begin
                mem_req  = 1'b1;
                dc_op    = 1'b1;
                dc_wdata = {(`STRB_WIDTH/2){reg2[15:0]}};
                // odd address leaves the strobe empty, the request is dropped anyway
                if (!mem_addr[0]) begin
                    dc_wstrb = mem_addr[1] ? 4'b1100 : 4'b0011;
                end
            end
            ALU_STW: begin
                mem_req  = 1'b1;
                dc_op    = 1'b1;
                dc_wdata = reg2;
                dc_wstrb = '1;
            end
            ALU_SCW: begin
                // sc without a valid link never reaches the cache
                if (llbit_now) begin
                    mem_req  = 1'b1;
                    dc_op    = 1'b1;
                    dc_wdata = reg2;
                    dc_wstrb = '1;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        case (aluop)
            ALU_LDH, ALU_LDHU, ALU_STH: begin
                exception = mem_addr[0];
            end
            ALU_LDW, ALU_LLW, ALU_STW, ALU_SCW: begin
                exception = |mem_addr[1:0];
            end
            default: exception = 1'b0;
        endcase
    end

    assign exc_cause = exception ? `EXC_ALE : '0;
    assign dc_valid  = in_valid && mem_req && !exception;

endmodule

// File: tb.f
+incdir+hdl
hdl/ex_pkg.sv
hdl/alu.sv
hdl/mem_access_unit.sv
hdl/llbit_ctrl.sv
hdl/ex_stage.sv
test/ex_stage_properties.sv
test/ex_stage_tb.sv

// File: test/ex_stage_properties.sv
`timescale 1ns/10ps

module ex_stage_properties
    import ex_pkg::*;
(
    input logic   clk,
    input logic   reset,
    input logic   pause,
    input logic   dc_valid,
    input logic   dc_op,
    input logic   dc_addr_ok,
    input wstrb_t dc_wstrb,
    input logic   out_valid,
    input logic   out_exception
);

    // the register comes out of reset as a bubble
    a_reset_bubble: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    a_pause_cause: assert property (@(posedge clk) disable iff (reset)
        pause |-> (dc_valid && !dc_addr_ok))
        else $error("pause without a refused cache request");

    a_write_strobe: assert property (@(posedge clk) disable iff (reset)
        (dc_valid && dc_op) |-> (dc_wstrb != '0))
        else $error("cache write request with an empty strobe");

    a_exc_valid: assert property (@(posedge clk) disable iff (reset)
        out_exception |-> out_valid)
        else $error("out_exception raised on a bubble");

endmodule

bind ex_stage ex_stage_properties i_ex_stage_properties (
    .clk           (clk),
    .reset         (reset),
    .pause         (pause),
    .dc_valid      (dc_valid),
    .dc_op         (dc_op),
    .dc_addr_ok    (dc_addr_ok),
    .dc_wstrb      (dc_wstrb),
    .out_valid     (out_valid),
    .out_exception (out_exception)
);

// File: test/ex_stage_tb.sv
`timescale 1ns/10ps
`include "ex_params.svh"

module ex_stage_tb
    import ex_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int ARITH_REPS   = 8;
    localparam int STALL_ROUNDS = 4;
    // arith, stores, loads, ll/sc and stall operations
    localparam int OPS_TOTAL    = 14 * ARITH_REPS + 12 + 20 + 36 + STALL_ROUNDS;

    logic       clk = 1'b0;
    logic       reset;
    logic       in_valid;
    alu_op_t    aluop;
    word_t      reg1;
    word_t      reg2;
    word_t      inst;
    logic       reg_write_en;
    reg_addr_t  reg_write_addr;
    logic       llbit;
    logic       mem_csr_write_en;
    csr_addr_t  mem_csr_write_addr;
    word_t      mem_csr_write_data;
    logic       wb_csr_write_en;
    csr_addr_t  wb_csr_write_addr;
    word_t      wb_csr_write_data;
    logic       dc_valid;
    logic       dc_op;
    word_t      dc_addr;
    wstrb_t     dc_wstrb;
    word_t      dc_wdata;
    logic       dc_addr_ok;
    logic       pause;
    logic       out_valid;
    logic       out_reg_write_en;
    reg_addr_t  out_reg_write_addr;
    word_t      out_reg_write_data;
    word_t      out_mem_addr;
    logic       out_exception;
    exc_cause_t out_exc_cause;
    logic       out_csr_write_en;
    csr_addr_t  out_csr_addr;
    word_t      out_csr_data;
    logic       out_is_llw_scw;

    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int unsigned seed_val;

    ex_stage i_ex_stage (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_strb(string name, wstrb_t got, wstrb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_cause(string name, exc_cause_t got, exc_cause_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
        end
    endtask

    function automatic word_t model_alu(alu_op_t op, word_t a, word_t b);
        longint          sprod;
        longint unsigned uprod;
        sprod = longint'($signed(a)) * longint'($signed(b));
        uprod = {32'b0, a} * {32'b0, b};
        case (op)
            ALU_OR:    return a | b;
            ALU_NOR:   return ~(a | b);
            ALU_AND:   return a & b;
            ALU_XOR:   return a ^ b;
            ALU_SLL:   return a << b[4:0];
            ALU_SRL:   return a >> b[4:0];
            ALU_SRA:   return word_t'($signed(a) >>> b[4:0]);
            ALU_ADD:   return a + b;
            ALU_SUB:   return a - b;
            ALU_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU:  return (a < b) ? 32'd1 : 32'd0;
            ALU_MUL:   return sprod[31:0];
            ALU_MULH:  return sprod[63:32];
            ALU_MULHU: return uprod[63:32];
            default:   return '0;
        endcase
    endfunction

    function automatic logic misaligned(alu_op_t op, word_t addr);
        case (op)
            ALU_LDH, ALU_LDHU, ALU_STH:         return addr[0];
            ALU_LDW, ALU_LLW, ALU_STW, ALU_SCW: return addr[1:0] != 2'b00;
            default:                            return 1'b0;
        endcase
    endfunction

    task automatic drive_op(alu_op_t op, word_t a, word_t b, word_t ins);
        @(posedge clk);
        in_valid       <= 1'b1;
        aluop          <= op;
        reg1           <= a;
        reg2           <= b;
        inst           <= ins;
        reg_write_en   <= 1'($urandom);
        reg_write_addr <= reg_addr_t'($urandom);
        @(negedge clk);
    endtask

    // waits out back-pressure, then lets the stage load and checks the register
    task automatic wait_load();
        int waited;
        waited = 0;
        while (pause && waited < 64) begin
            @(negedge clk);
            waited++;
        end
        if (pause) begin
            errors++;
            $display("pause stuck high for %0d cycles, request never accepted", waited);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b1);
        check_bit("out_reg_write_en", out_reg_write_en, reg_write_en);
        check_word("out_reg_write_addr", word_t'(out_reg_write_addr), word_t'(reg_write_addr));
    endtask

    task automatic check_fault(logic fault);
        check_bit("out_exception", out_exception, fault);
        if (fault) begin
            check_cause("out_exc_cause", out_exc_cause, `EXC_ALE);
        end
    endtask

    task automatic end_test(string name, int base);
        tests_run++;
        if (errors == base) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - base);
        end
    endtask

    task automatic test_reset();
        int base;
        base = errors;
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("out_reg_write_en", out_reg_write_en, 1'b0);
        check_bit("out_csr_write_en", out_csr_write_en, 1'b0);
        check_bit("out_exception", out_exception, 1'b0);
        end_test("reset", base);
    endtask

    task automatic test_arith();
        alu_op_t ops[14];
        word_t   a;
        word_t   b;
        int      base;
        base = errors;
        ops = '{ALU_OR, ALU_NOR, ALU_AND, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
                ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_MUL, ALU_MULH, ALU_MULHU};
        foreach (ops[i]) begin
            for (int r = 0; r < ARITH_REPS; r++) begin
                a = $urandom;
                b = $urandom;
                // sign corner for compares and high products
                if (r == 1) begin
                    a = 32'h8000_0000;
                    b = 32'h0000_0001;
                end
                drive_op(ops[i], a, b, $urandom);
                check_bit("dc_valid", dc_valid, 1'b0);
                wait_load();
                check_word("out_reg_write_data", out_reg_write_data, model_alu(ops[i], a, b));
                check_bit("out_csr_write_en", out_csr_write_en, 1'b0);
                check_bit("out_exception", out_exception, 1'b0);
            end
        end
        end_test("arith", base);
    endtask

    task automatic test_stores();
        alu_op_t     ops[3];
        logic [11:0] imm;
        word_t       a;
        word_t       b;
        word_t       ins;
        word_t       addr;
        word_t       exp_data;
        wstrb_t      exp_strb;
        logic        fault;
        int          base;
        base = errors;
        ops = '{ALU_STB, ALU_STH, ALU_STW};
        foreach (ops[i]) begin
            for (int off = 0; off < 4; off++) begin
                a = $urandom & 32'hffff_fffc;
                b = $urandom;
                imm = 12'($urandom);
                imm[1:0] = 2'(off);
                ins = $urandom;
                ins[21:10] = imm;
                addr = a + {{20{imm[11]}}, imm};
                fault = misaligned(ops[i], addr);
                case (ops[i])
                    ALU_STB: begin
                        exp_strb = '0;
                        exp_strb[addr[1:0]] = 1'b1;
                        exp_data = {4{b[7:0]}};
                    end
                    ALU_STH: begin
                        exp_strb = addr[1] ? 4'b1100 : 4'b0011;
                        exp_data = {2{b[15:0]}};
                    end
                    default: begin
                        exp_strb = 4'b1111;
                        exp_data = b;
                    end
                endcase
                drive_op(ops[i], a, b, ins);
                check_word("dc_addr", dc_addr, addr);
                check_bit("dc_valid", dc_valid, !fault);
                if (!fault) begin
                    check_bit("dc_op", dc_op, 1'b1);
                    check_strb("dc_wstrb", dc_wstrb, exp_strb);
                    check_word("dc_wdata", dc_wdata, exp_data);
                end
                wait_load();
                check_fault(fault);
            end
        end
        end_test("stores", base);
    endtask

    task automatic test_loads();
        alu_op_t ops[5];
        word_t   a;
        word_t   b;
        word_t   addr;
        logic    fault;
        int      base;
        base = errors;
        ops = '{ALU_LDB, ALU_LDBU, ALU_LDH, ALU_LDHU, ALU_LDW};
        foreach (ops[i]) begin
            for (int off = 0; off < 4; off++) begin
                a = $urandom;
                b = $urandom;
                b[1:0] = 2'(off) - a[1:0];
                addr = a + b;
                fault = misaligned(ops[i], addr);
                drive_op(ops[i], a, b, $urandom);
                check_word("dc_addr", dc_addr, addr);
                check_bit("dc_valid", dc_valid, !fault);
                check_bit("dc_op", dc_op, 1'b0);
                wait_load();
                check_word("out_mem_addr", out_mem_addr, addr);
                check_word("out_reg_write_data", out_reg_write_data, '0);
                check_fault(fault);
            end
        end
        end_test("loads", base);
    endtask

    // m and w pick no write, a link register write or a write elsewhere
    task automatic set_forwarding(int m, int w, logic lb);
        @(posedge clk);
        llbit              <= lb;
        mem_csr_write_en   <= (m != 0);
        mem_csr_write_addr <= (m == 2) ? `CSR_LLBCTL + 14'd1 : `CSR_LLBCTL;
        mem_csr_write_data <= {31'($urandom), (m == 1) ? lb : !lb};
        wb_csr_write_en    <= (w != 0);
        wb_csr_write_addr  <= (w == 2) ? `CSR_LLBCTL + 14'd2 : `CSR_LLBCTL;
        wb_csr_write_data  <= {31'($urandom), !lb};
    endtask

    task automatic test_llsc();
        word_t a;
        word_t b;
        word_t ins;
        word_t addr;
        logic  lb;
        logic  now;
        int    base;
        base = errors;
        for (int m = 0; m < 3; m++) begin
            for (int w = 0; w < 3; w++) begin
                for (int l = 0; l < 2; l++) begin
                    lb = l[0];
                    now = (m == 1) ? lb : ((w == 1) ? !lb : lb);
                    set_forwarding(m, w, lb);
                    a = $urandom & 32'hffff_fffc;
                    b = $urandom;
                    ins = $urandom;
                    addr = a + {{16{ins[23]}}, ins[23:10], 2'b00};
                    drive_op(ALU_SCW, a, b, ins);
                    check_word("dc_addr", dc_addr, addr);
                    check_bit("dc_valid", dc_valid, now);
                    if (now) begin
                        check_bit("dc_op", dc_op, 1'b1);
                        check_strb("dc_wstrb", dc_wstrb, 4'b1111);
                        check_word("dc_wdata", dc_wdata, b);
                    end
                    wait_load();
                    check_word("out_reg_write_data", out_reg_write_data, {31'b0, now});
                    check_bit("out_csr_write_en", out_csr_write_en, now);
                    check_bit("out_is_llw_scw", out_is_llw_scw, now);
                    if (now) begin
                        check_word("out_csr_addr", word_t'(out_csr_addr), word_t'(`CSR_LLBCTL));
                        check_word("out_csr_data", out_csr_data, 32'd0);
                    end
                    check_fault(1'b0);

                    b = $urandom & 32'hffff_fffc;
                    drive_op(ALU_LLW, a, b, $urandom);
                    check_bit("dc_valid", dc_valid, 1'b1);
                    check_bit("dc_op", dc_op, 1'b0);
                    wait_load();
                    check_word("out_mem_addr", out_mem_addr, a + b);
                    check_bit("out_csr_write_en", out_csr_write_en, 1'b1);
                    check_bit("out_is_llw_scw", out_is_llw_scw, 1'b1);
                    check_word("out_csr_addr", word_t'(out_csr_addr), word_t'(`CSR_LLBCTL));
                    check_word("out_csr_data", out_csr_data, 32'd1);
                end
            end
        end
        @(posedge clk);
        mem_csr_write_en <= 1'b0;
        wb_csr_write_en  <= 1'b0;
        end_test("llsc", base);
    endtask

    task automatic test_stall();
        alu_op_t op;
        word_t   a;
        word_t   b;
        word_t   ins;
        word_t   addr;
        int      hold;
        int      base;
        base = errors;
        for (int r = 0; r < STALL_ROUNDS; r++) begin
            op = r[0] ? ALU_LDW : ALU_STW;
            a = $urandom & 32'hffff_fffc;
            b = $urandom & 32'hffff_fffc;
            ins = $urandom;
            ins[11:10] = 2'b00;
            addr = r[0] ? a + b : a + {{20{ins[21]}}, ins[21:10]};
            hold = 1 + ($urandom % 8);
            @(posedge clk);
            dc_addr_ok <= 1'b0;
            drive_op(op, a, b, ins);
            for (int c = 0; c < hold; c++) begin
                check_bit("pause", pause, 1'b1);
                check_bit("out_valid", out_valid, 1'b0);
                @(negedge clk);
            end
            @(posedge clk);
            dc_addr_ok <= 1'b1;
            @(negedge clk);
            check_bit("pause", pause, 1'b0);
            check_bit("out_valid", out_valid, 1'b0);
            wait_load();
            check_word("out_mem_addr", out_mem_addr, addr);
        end
        end_test("stall", base);
    endtask

    initial begin
        seed_val = $urandom(30);
        reset = 1'b1;
        in_valid = 1'b0;
        aluop = ALU_NOP;
        reg1 = '0;
        reg2 = '0;
        inst = '0;
        reg_write_en = 1'b0;
        reg_write_addr = '0;
        llbit = 1'b0;
        mem_csr_write_en = 1'b0;
        mem_csr_write_addr = '0;
        mem_csr_write_data = '0;
        wb_csr_write_en = 1'b0;
        wb_csr_write_addr = '0;
        wb_csr_write_data = '0;
        dc_addr_ok = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_arith();
        test_stores();
        test_loads();
        test_llsc();
        test_stall();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(OPS_TOTAL * 20 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, test sequence did not finish",
                 OPS_TOTAL * 20);
        $display("TB FAILED");
        $finish;
    end

endmodule
